//--- rs_pkg.sv
// Reservation station shared definitions
// Widths, entry count and the operand and entry records used by the
// capture units and the station
`default_nettype none

package rs_pkg;

	// ====================
	// Sizes
	// ====================

	// Number of station entries
	localparam int NUM_ENTRIES = 3;
	// Width of an entry index
	localparam int IDX_W = $clog2(NUM_ENTRIES);
	// Physical register number width
	localparam int PREG_W = 7;
	// Operand value width
	localparam int VALUE_W = 32;
	// Reorder-buffer index width
	localparam int ROB_W = 5;
	// One stomp bit per reorder-buffer slot
	localparam int ROB_SIZE = 1 << ROB_W;
	// Opcode width
	localparam int OP_W = 8;

	// ====================
	// Types
	// ====================

	typedef logic [PREG_W-1:0] preg_t;
	typedef logic [VALUE_W-1:0] value_t;
	typedef logic [ROB_W-1:0] rob_idx_t;

	// A source operand holds its value once valid, otherwise it waits on preg
	typedef struct packed {
		logic valid;
		preg_t preg;
		value_t value;
	} operand_t;

	// Ready is kept registered so issue selection never sees a long compare path
	typedef struct packed {
		logic busy;
		logic ready;
		logic [OP_W-1:0] op;
		rob_idx_t rndx;
		operand_t a;
		operand_t b;
	} rs_entry_t;

endpackage

`default_nettype wire

//--- bypass_if.sv
// Result bypass bus
// One-cycle write pulse carrying the destination register and its value
`timescale 1ns/100ps
`default_nettype none

interface bypass_if import rs_pkg::*; ();

	// High for exactly one cycle per result write
	logic valid;
	// Destination physical register of the result
	preg_t preg;
	// Result value
	value_t value;

	// Producer side, driven from the top-level ports
	modport drv (
		output valid,
		output preg,
		output value
	);

	// Listener side, used by every operand capture unit
	modport snoop (
		input valid,
		input preg,
		input value
	);

endinterface

`default_nettype wire

//--- rs_operand_capture.sv
// Reservation station operand capture
// Watches the bypass bus for one source operand and flags every waiting
// entry, and the operand being dispatched, whose register is written
`timescale 1ns/100ps
`default_nettype none

module rs_operand_capture import rs_pkg::*; (
	bypass_if.snoop byp,
	// This operand's field of every stored entry
	input wire operand_t [NUM_ENTRIES-1:0] ent_ops_i,
	input wire logic [NUM_ENTRIES-1:0] ent_busy_i,
	// The same operand of the incoming dispatch
	input wire operand_t in_op_i,
	output logic [NUM_ENTRIES-1:0] cap_o,
	output logic in_cap_o,
	output value_t cap_val_o
);

	// ====================
	// Match logic
	// ====================

	// True when a waiting operand is named by the current bypass write
	function automatic logic hit(input operand_t op, input logic wr, input preg_t wr_preg);
		return wr && !op.valid && (op.preg == wr_preg);
	endfunction

	// Stored entries
	// A free entry may hold a stale register number, so busy qualifies the match
	always_comb begin
		for (int i = 0; i < NUM_ENTRIES; i++) begin
			cap_o[i] = ent_busy_i[i] && hit(ent_ops_i[i], byp.valid, byp.preg);
		end
	end

	// Incoming slot
	// The station only uses this strobe when a dispatch is actually written,
	// so there is no dispatch qualifier here
	assign in_cap_o = hit(in_op_i, byp.valid, byp.preg);

	// The captured value is the bypass value itself, for every strobe above
	assign cap_val_o = byp.value;

endmodule

`default_nettype wire

//--- rs_station.sv
// Reservation station entry storage
// Holds three entries, allocates the lowest free one on dispatch, merges
// operand captures, and issues or stomp-frees the lowest ready entry
`timescale 1ns/100ps
`default_nettype none

module rs_station import rs_pkg::*; (
	input wire logic clk,
	input wire logic rst,
	// Dispatch
	input wire logic dispatch_i,
	input wire logic [OP_W-1:0] disp_op_i,
	input wire rob_idx_t disp_rndx_i,
	input wire operand_t disp_a_i,
	input wire operand_t disp_b_i,
	// Capture strobes from the A and B units
	input wire logic [NUM_ENTRIES-1:0] cap_a_i,
	input wire logic [NUM_ENTRIES-1:0] cap_b_i,
	input wire logic in_cap_a_i,
	input wire logic in_cap_b_i,
	input wire value_t cap_a_val_i,
	input wire value_t cap_b_val_i,
	// Back-pressure and cancel
	input wire logic stall_i,
	input wire logic [ROB_SIZE-1:0] stomp_i,
	// Stored operand fields for the capture units
	output operand_t [NUM_ENTRIES-1:0] ent_a_o,
	output operand_t [NUM_ENTRIES-1:0] ent_b_o,
	output logic [NUM_ENTRIES-1:0] ent_busy_o,
	output logic full_o,
	// Issue
	output logic issue_o,
	output logic [OP_W-1:0] iss_op_o,
	output rob_idx_t iss_rndx_o,
	output value_t iss_a_o,
	output value_t iss_b_o
);

	rs_entry_t [NUM_ENTRIES-1:0] ent_q;
	rs_entry_t [NUM_ENTRIES-1:0] ent_d;
	logic alloc_any;
	logic [IDX_W-1:0] alloc_idx;
	logic sel_any;
	logic [IDX_W-1:0] sel_idx;
	logic sel_stomp;
	logic iss_en;
	logic take;
	logic pstall_q;

	// ====================
	// Allocation and select
	// ====================

	// Walk downwards so the lowest index wins in both searches
	always_comb begin
		alloc_any = 1'b0;
		alloc_idx = '0;
		sel_any = 1'b0;
		sel_idx = '0;
		for (int i = NUM_ENTRIES - 1; i >= 0; i--) begin
			if (!ent_q[i].busy) begin
				alloc_any = 1'b1;
				alloc_idx = IDX_W'(i);
			end
			if (ent_q[i].ready) begin
				sel_any = 1'b1;
				sel_idx = IDX_W'(i);
			end
		end
	end

	// Nothing leaves while stalled, nor on the first edge after stall drops
	assign iss_en = !stall_i && !pstall_q;
	assign take = sel_any && iss_en;

	// A stomped pick is freed but never reaches the unit
	assign sel_stomp = stomp_i[ent_q[sel_idx].rndx];

	// ====================
	// Next entry state
	// ====================

	always_comb begin
		ent_d = ent_q;
		for (int i = 0; i < NUM_ENTRIES; i++) begin
			// Bypass writes to operands that are still waiting
			if (cap_a_i[i]) begin
				ent_d[i].a.valid = 1'b1;
				ent_d[i].a.value = cap_a_val_i;
			end
			if (cap_b_i[i]) begin
				ent_d[i].b.valid = 1'b1;
				ent_d[i].b.value = cap_b_val_i;
			end
			if (take && (sel_idx == IDX_W'(i))) begin
				ent_d[i].busy = 1'b0;
			end
			// New instruction, with a same-cycle bypass folded in
			if (dispatch_i && alloc_any && (alloc_idx == IDX_W'(i))) begin
				ent_d[i].busy = 1'b1;
				ent_d[i].op = disp_op_i;
				ent_d[i].rndx = disp_rndx_i;
				ent_d[i].a = disp_a_i;
				ent_d[i].b = disp_b_i;
				if (in_cap_a_i) begin
					ent_d[i].a.valid = 1'b1;
					ent_d[i].a.value = cap_a_val_i;
				end
				if (in_cap_b_i) begin
					ent_d[i].b.valid = 1'b1;
					ent_d[i].b.value = cap_b_val_i;
				end
			end
			// Ready follows the next-state valids so issue can go one edge later
			ent_d[i].ready = ent_d[i].busy && ent_d[i].a.valid && ent_d[i].b.valid;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < NUM_ENTRIES; i++) begin
				ent_q[i].busy <= 1'b0;
				ent_q[i].ready <= 1'b0;
				ent_q[i].a.valid <= 1'b0;
				ent_q[i].b.valid <= 1'b0;
			end
		end else begin
			ent_q <= ent_d;
		end
	end

	// ====================
	// Issue registers
	// ====================

	always_ff @(posedge clk) begin
		if (rst) begin
			issue_o <= 1'b0;
			pstall_q <= 1'b0;
		end else begin
			issue_o <= take && !sel_stomp;
			pstall_q <= stall_i;
		end
	end

	// Payload is only meaningful alongside issue_o
	always_ff @(posedge clk) begin
		if (take) begin
			iss_op_o <= ent_q[sel_idx].op;
			iss_rndx_o <= ent_q[sel_idx].rndx;
			iss_a_o <= ent_q[sel_idx].a.value;
			iss_b_o <= ent_q[sel_idx].b.value;
		end
	end

	// Stored fields go out to the capture units
	always_comb begin
		for (int i = 0; i < NUM_ENTRIES; i++) begin
			ent_a_o[i] = ent_q[i].a;
			ent_b_o[i] = ent_q[i].b;
			ent_busy_o[i] = ent_q[i].busy;
		end
	end

	// A dispatch seen while this is high is dropped
	assign full_o = &ent_busy_o;

endmodule

`default_nettype wire

//--- rs_top.sv
// Reservation station top level
// Drives the bypass bus from plain ports and wires two operand capture
// units to the entry storage
`timescale 1ns/100ps
`default_nettype none

module rs_top import rs_pkg::*; (
	input wire logic clk,
	input wire logic rst,
	input wire logic dispatch_i,
	input wire logic [OP_W-1:0] disp_op_i,
	input wire rob_idx_t disp_rndx_i,
	input wire logic disp_a_v_i,
	input wire preg_t disp_a_preg_i,
	input wire value_t disp_a_val_i,
	input wire logic disp_b_v_i,
	input wire preg_t disp_b_preg_i,
	input wire value_t disp_b_val_i,
	input wire logic byp_valid_i,
	input wire preg_t byp_preg_i,
	input wire value_t byp_val_i,
	input wire logic stall_i,
	input wire logic [ROB_SIZE-1:0] stomp_i,
	output logic full_o,
	output logic issue_o,
	output logic [OP_W-1:0] iss_op_o,
	output rob_idx_t iss_rndx_o,
	output value_t iss_a_o,
	output value_t iss_b_o
);

	operand_t disp_a;
	operand_t disp_b;
	operand_t [NUM_ENTRIES-1:0] ent_a;
	operand_t [NUM_ENTRIES-1:0] ent_b;
	logic [NUM_ENTRIES-1:0] ent_busy;
	logic [NUM_ENTRIES-1:0] cap_a;
	logic [NUM_ENTRIES-1:0] cap_b;
	logic in_cap_a;
	logic in_cap_b;
	value_t cap_a_val;
	value_t cap_b_val;

	// ====================
	// Bypass bus
	// ====================

	// The top level is the driver side of the bus
	bypass_if byp ();
	assign byp.valid = byp_valid_i;
	assign byp.preg = byp_preg_i;
	assign byp.value = byp_val_i;

	assign disp_a = '{valid: disp_a_v_i, preg: disp_a_preg_i, value: disp_a_val_i};
	assign disp_b = '{valid: disp_b_v_i, preg: disp_b_preg_i, value: disp_b_val_i};

	// ====================
	// Capture and storage
	// ====================

	rs_operand_capture u_cap_a (
		.byp(byp),
		.ent_ops_i(ent_a),
		.ent_busy_i(ent_busy),
		.in_op_i(disp_a),
		.cap_o(cap_a),
		.in_cap_o(in_cap_a),
		.cap_val_o(cap_a_val)
	);

	rs_operand_capture u_cap_b (
		.byp(byp),
		.ent_ops_i(ent_b),
		.ent_busy_i(ent_busy),
		.in_op_i(disp_b),
		.cap_o(cap_b),
		.in_cap_o(in_cap_b),
		.cap_val_o(cap_b_val)
	);

	rs_station u_station (
		.clk(clk),
		.rst(rst),
		.dispatch_i(dispatch_i),
		.disp_op_i(disp_op_i),
		.disp_rndx_i(disp_rndx_i),
		.disp_a_i(disp_a),
		.disp_b_i(disp_b),
		.cap_a_i(cap_a),
		.cap_b_i(cap_b),
		.in_cap_a_i(in_cap_a),
		.in_cap_b_i(in_cap_b),
		.cap_a_val_i(cap_a_val),
		.cap_b_val_i(cap_b_val),
		.stall_i(stall_i),
		.stomp_i(stomp_i),
		.ent_a_o(ent_a),
		.ent_b_o(ent_b),
		.ent_busy_o(ent_busy),
		.full_o(full_o),
		.issue_o(issue_o),
		.iss_op_o(iss_op_o),
		.iss_rndx_o(iss_rndx_o),
		.iss_a_o(iss_a_o),
		.iss_b_o(iss_b_o)
	);

endmodule

`default_nettype wire

//--- rs_chk.sv
// Reservation station protocol checker
// Stall, issue and full properties, bound into the top level
`timescale 1ns/100ps
`default_nettype none

module rs_chk (
	input wire logic clk,
	input wire logic rst,
	input wire logic dispatch_i,
	input wire logic stall_i,
	input wire logic issue_i,
	input wire logic full_i
);

	// Number of property failures so far
	int unsigned fail_count = 0;

	// ====================
	// Stall
	// ====================

	// Nothing is picked at an edge that sees stall high
	a_stall_quiet: assert property (@(posedge clk) disable iff (rst) stall_i |=> !issue_i)
	else begin
		fail_count++;
		$error("issue_o high after a stalled cycle");
	end

	// The edge at which stall drops is also kept quiet
	a_release_quiet: assert property (@(posedge clk) disable iff (rst) $fell(stall_i) |=> !issue_i)
	else begin
		fail_count++;
		$error("issue_o high right after stall release");
	end

	// Full can only rise through a dispatch
	a_full_rise: assert property (@(posedge clk) disable iff (rst) $rose(full_i) |-> $past(dispatch_i))
	else begin
		fail_count++;
		$error("full_o rose without a dispatch");
	end

endmodule

bind rs_top rs_chk u_chk (
	.clk(clk),
	.rst(rst),
	.dispatch_i(dispatch_i),
	.stall_i(stall_i),
	.issue_i(issue_o),
	.full_i(full_o)
);

`default_nettype wire

//--- tb_rs.sv
// Reservation station testbench
// Replays the vector file against the station and checks every issue
// against a scoreboard of operand values kept by ROB index
`timescale 1ns/100ps
`default_nettype none

module tb_rs import rs_pkg::*; ();

	logic clk = 1'b0;
	logic rst;
	logic dispatch;
	logic [OP_W-1:0] disp_op;
	rob_idx_t disp_rndx;
	logic disp_a_v;
	preg_t disp_a_preg;
	value_t disp_a_val;
	logic disp_b_v;
	preg_t disp_b_preg;
	value_t disp_b_val;
	logic byp_valid;
	preg_t byp_preg;
	value_t byp_val;
	logic stall;
	logic [ROB_SIZE-1:0] stomp;
	logic full;
	logic issue;
	logic [OP_W-1:0] iss_op;
	rob_idx_t iss_rndx;
	value_t iss_a;
	value_t iss_b;

	// Scoreboard, one slot per ROB index
	// Live means dispatched into the station and not yet seen on issue
	logic sb_live [ROB_SIZE];
	logic sb_stomped [ROB_SIZE];
	logic [OP_W-1:0] sb_op [ROB_SIZE];
	operand_t sb_a [ROB_SIZE];
	operand_t sb_b [ROB_SIZE];

	int value_errs = 0;
	int other_errs = 0;
	int limit_cycles = 0;
	// Set when the vectors expect a full station in the current cycle
	logic expect_full = 1'b0;

	always #2 clk = ~clk;

	rs_top uut (
		.clk(clk),
		.rst(rst),
		.dispatch_i(dispatch),
		.disp_op_i(disp_op),
		.disp_rndx_i(disp_rndx),
		.disp_a_v_i(disp_a_v),
		.disp_a_preg_i(disp_a_preg),
		.disp_a_val_i(disp_a_val),
		.disp_b_v_i(disp_b_v),
		.disp_b_preg_i(disp_b_preg),
		.disp_b_val_i(disp_b_val),
		.byp_valid_i(byp_valid),
		.byp_preg_i(byp_preg),
		.byp_val_i(byp_val),
		.stall_i(stall),
		.stomp_i(stomp),
		.full_o(full),
		.issue_o(issue),
		.iss_op_o(iss_op),
		.iss_rndx_o(iss_rndx),
		.iss_a_o(iss_a),
		.iss_b_o(iss_b)
	);

	// ====================
	// Compare tasks
	// ====================

	task automatic check_flag(input string name, input logic exp, input logic act);
		if (act !== exp) begin
			value_errs++;
			$display("Error at %t: %s expected %b, got %b", $time, name, exp, act);
		end
	endtask

	task automatic check_rob(input string name, input rob_idx_t exp, input rob_idx_t act);
		if (act !== exp) begin
			value_errs++;
			$display("Error at %t: %s expected %h, got %h", $time, name, exp, act);
		end
	endtask

	task automatic check_value(input string name, input value_t exp, input value_t act);
		if (act !== exp) begin
			value_errs++;
			$display("Error at %t: %s expected %h, got %h", $time, name, exp, act);
		end
	endtask

	// Whole issue payload against what the scoreboard holds for that ROB index
	task automatic check_issue(input rob_idx_t rndx, input logic [OP_W-1:0] op,
		input value_t a, input value_t b);
		if (iss_op !== op) begin
			value_errs++;
			$display("Error at %t: iss_op_o of ROB %0d expected %h, got %h",
				$time, rndx, op, iss_op);
		end
		check_value($sformatf("iss_a_o of ROB %0d", rndx), a, iss_a);
		check_value($sformatf("iss_b_o of ROB %0d", rndx), b, iss_b);
	endtask

	// A bypass write resolves every recorded operand still waiting on its register
	task automatic apply_bypass();
		for (int r = 0; r < ROB_SIZE; r++) begin
			if (sb_live[r] && !sb_a[r].valid && sb_a[r].preg == byp_preg) begin
				sb_a[r].valid = 1'b1;
				sb_a[r].value = byp_val;
			end
			if (sb_live[r] && !sb_b[r].valid && sb_b[r].preg == byp_preg) begin
				sb_b[r].valid = 1'b1;
				sb_b[r].value = byp_val;
			end
		end
	endtask

	// ====================
	// Issue monitor
	// ====================

	// Outputs are registered, so mid-cycle they are settled
	always @(negedge clk) begin
		if (!rst && issue === 1'b1) begin
			if (!sb_live[iss_rndx]) begin
				other_errs++;
				$display("ROB index %0d issued at %t but was not waiting", iss_rndx, $time);
			end else if (sb_stomped[iss_rndx]) begin
				other_errs++;
				$display("ROB index %0d issued at %t although stomped", iss_rndx, $time);
			end else if (!sb_a[iss_rndx].valid || !sb_b[iss_rndx].valid) begin
				other_errs++;
				$display("ROB index %0d issued at %t before its operands were written",
					iss_rndx, $time);
			end else begin
				check_issue(iss_rndx, sb_op[iss_rndx], sb_a[iss_rndx].value,
					sb_b[iss_rndx].value);
			end
			sb_live[iss_rndx] = 1'b0;
		end
	end

	// Watchdog sized from the cycle count of the vectors
	initial begin
		wait (limit_cycles != 0);
		#(limit_cycles * 4);
		$display("Run did not finish within %0d cycles", limit_cycles);
		$display("RESULT: FAIL");
		$finish;
	end

	// ====================
	// Vector replay
	// ====================

	initial begin
		int fd;
		int code;
		int n;
		int total;
		int asrt_errs;
		logic [7:0] cmd;
		logic e;
		rob_idx_t r;
		logic [ROB_SIZE-1:0] k;
		string line;
		$timeformat(-9, 1, " ns", 0);
		rst = 1'b1;
		dispatch = 1'b0;
		disp_op = '0;
		disp_rndx = '0;
		disp_a_v = 1'b0;
		disp_a_preg = '0;
		disp_a_val = '0;
		disp_b_v = 1'b0;
		disp_b_preg = '0;
		disp_b_val = '0;
		byp_valid = 1'b0;
		byp_preg = '0;
		byp_val = '0;
		stall = 1'b0;
		stomp = '0;
		for (int i = 0; i < ROB_SIZE; i++) begin
			sb_live[i] = 1'b0;
			sb_stomped[i] = 1'b0;
		end
		// First pass only adds up the idle cycles to size the watchdog
		total = 0;
		fd = $fopen("rs_vectors.txt", "r");
		if (fd == 0) begin
			other_errs++;
			$display("Cannot open rs_vectors.txt");
		end else begin
			while ($fscanf(fd, "%s", cmd) == 1) begin
				if (cmd == "I") begin
					code = $fscanf(fd, "%d", n);
					total += n;
				end else begin
					code = $fgets(line, fd);
				end
			end
			$fclose(fd);
		end
		limit_cycles = total + 3 + 40;
		repeat (3) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;
		fd = $fopen("rs_vectors.txt", "r");
		if (fd != 0) begin
			while ($fscanf(fd, "%s", cmd) == 1) begin
				case (cmd)
					"D": begin
						code = $fscanf(fd, "%h %h %h %h %h %h %h %h", disp_op, disp_rndx,
							disp_a_v, disp_a_preg, disp_a_val, disp_b_v, disp_b_preg,
							disp_b_val);
						dispatch = 1'b1;
						// A dispatch into a full station is dropped
						if (!expect_full) begin
							sb_live[disp_rndx] = 1'b1;
							sb_stomped[disp_rndx] = stomp[disp_rndx];
							sb_op[disp_rndx] = disp_op;
							sb_a[disp_rndx] = '{valid: disp_a_v, preg: disp_a_preg,
								value: disp_a_val};
							sb_b[disp_rndx] = '{valid: disp_b_v, preg: disp_b_preg,
								value: disp_b_val};
						end
					end
					"B": begin
						code = $fscanf(fd, "%h %h", byp_preg, byp_val);
						byp_valid = 1'b1;
					end
					"S": code = $fscanf(fd, "%h", stall);
					"K": begin
						code = $fscanf(fd, "%h", k);
						stomp = k;
						for (int i = 0; i < ROB_SIZE; i++) begin
							if (sb_live[i] && k[i]) begin
								sb_stomped[i] = 1'b1;
							end
						end
					end
					"F": begin
						code = $fscanf(fd, "%h", e);
						expect_full = e;
						check_flag("full_o", e, full);
					end
					"X": begin
						code = $fscanf(fd, "%h %h", e, r);
						check_flag("issue_o", e, issue);
						if (e) begin
							check_rob("iss_rndx_o", r, iss_rndx);
						end
					end
					"I": begin
						code = $fscanf(fd, "%d", n);
						repeat (n) begin
							// Model captures in the cycle the bypass is driven
							if (byp_valid) begin
								apply_bypass();
							end
							@(negedge clk);
							dispatch = 1'b0;
							byp_valid = 1'b0;
							expect_full = 1'b0;
						end
					end
					"#": code = $fgets(line, fd);
					default: begin
						other_errs++;
						$display("Unknown command %s in the vector file", cmd);
						code = $fgets(line, fd);
					end
				endcase
			end
			$fclose(fd);
		end
		repeat (4) @(negedge clk);
		for (int i = 0; i < ROB_SIZE; i++) begin
			if (sb_live[i] && !sb_stomped[i]) begin
				other_errs++;
				$display("ROB index %0d was dispatched but never issued", i);
			end
		end
		asrt_errs = uut.u_chk.fail_count;
		$display("Errors: %0d value, %0d scoreboard, %0d assertion",
			value_errs, other_errs, asrt_errs);
		if (value_errs == 0 && other_errs == 0 && asrt_errs == 0) begin
			$display("RESULT: PASS");
		end else begin
			$display("RESULT: FAIL");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- rs_vectors.txt
# D op rndx a_v a_preg a_val b_v b_preg b_val | B preg val | S stall | K stomp mask
# F full and X issue rndx are checked now | I cycles to advance (decimal), rest hex
# Both operands valid, issue one cycle after the write
D 11 01 1 00 00000100 1 00 00000200
I 2
X 1 01
I 1
X 0 00
# Both operands wait on the bypass
D 22 02 0 05 00000000 0 06 00000000
I 1
B 05 0000aaaa
I 1
B 06 0000bbbb
I 1
X 0 00
I 1
X 1 02
# Operand A captured in the cycle of its own dispatch
D 33 03 0 07 00000000 1 00 00000333
B 07 00007777
I 2
X 1 03
# Fill all three entries, a fourth dispatch is dropped
D 44 04 0 10 00000000 1 00 00000004
I 1
D 45 05 0 11 00000000 1 00 00000005
I 1
D 46 06 0 12 00000000 1 00 00000006
F 0
I 1
F 1
D 47 07 1 00 00000007 1 00 00000007
I 1
B 11 00001111
I 1
F 1
I 1
X 1 05
F 0
B 10 00001010
I 1
B 12 00001212
I 1
X 1 04
I 1
X 1 06
# Stall holds a ready entry, and the release cycle stays quiet
S 1
D 55 08 1 00 00000008 1 00 00000080
I 2
X 0 00
S 0
I 1
X 0 00
I 1
X 1 08
# Stomp frees an entry of a full station without issue
K 00000200
D 66 09 0 20 00000000 1 00 00000009
I 1
D 67 0a 0 21 00000000 1 00 0000000a
I 1
D 68 0b 0 22 00000000 1 00 0000000b
I 1
F 1
B 20 00002020
I 1
F 1
I 1
X 0 00
F 0
K 00000000
D 69 0c 1 00 0000000c 1 00 0000000c
I 2
X 1 0c
B 21 00002121
I 1
B 22 00002222
I 1
X 1 0a
I 1
X 1 0b
I 3

//--- compile.f
rs_pkg.sv
bypass_if.sv
rs_operand_capture.sv
rs_station.sv
rs_top.sv
rs_chk.sv
tb_rs.sv

//--- Makefile
# Reservation station simulation with Verilator

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -f compile.f --top-module tb_rs

run: build
	@out=$$(./obj_dir/Vtb_rs +verilator+error+limit+100); echo "$$out"; \
	echo "$$out" | grep -qx "RESULT: PASS"

lint:
	verilator --lint-only -Wall --top-module rs_top \
		rs_pkg.sv bypass_if.sv rs_operand_capture.sv rs_station.sv rs_top.sv

clean:
	rm -rf obj_dir
